// File: egress_q.f
hw/egress_q_pkg.sv
hw/egress_q_intfs.sv
hw/buffer_pool.sv
hw/pkt_writer.sv
hw/desc_delay_fifo.sv
hw/pkt_reader.sv
hw/egress_q_top.sv
dv/tb_egress_q.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the egress queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_egress_q \
        -f egress_q.f -o sim_egress_q \
    && output="$(./obj_dir/sim_egress_q)" \
    && echo "$output" \
    && grep -qx "all tests passed" <<< "$output" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// File: dv/tb_egress_q.sv
`timescale 1ns/100ps
`default_nettype none

module tb_egress_q;
    localparam int DW         = egress_q_pkg::DATA_WID;
    localparam int PW         = egress_q_pkg::PORT_WID;
    localparam int NUM_PKTS   = 40;
    localparam int BYP_WORDS  = 40;
    localparam int ALL_PKTS   = 2 * NUM_PKTS + egress_q_pkg::NUM_BUFFERS + 1;
    localparam int ALL_WORDS  = ALL_PKTS * egress_q_pkg::BUFFER_WORDS + BYP_WORDS;
    localparam int TIMEOUT_CYC = ALL_WORDS * 40 + 2000;

    logic          clk;
    logic          i_rst_n;
    logic          i_valid;
    logic          o_ready;
    logic [DW-1:0] i_data;
    logic          i_last;
    logic [PW-1:0] i_port;
    logic          o_valid;
    logic          i_ready;
    logic [DW-1:0] o_data;
    logic          o_last;
    logic [PW-1:0] o_port;
    logic          i_bypass;
    logic          o_init_done;

    // Expected words as {port, last, data}
    logic [PW+DW:0] exp_q [$];
    logic [PW+DW:0] exp_word;
    logic           stall_q;
    logic [DW-1:0]  held_data;

    logic [31:0] rng;
    int          ready_mode;
    int          n_checks;
    int          n_errors;
    string       test_name;

    egress_q_top u_egress_q_top (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .o_ready     (o_ready),
        .i_data      (i_data),
        .i_last      (i_last),
        .i_port      (i_port),
        .o_valid     (o_valid),
        .i_ready     (i_ready),
        .o_data      (o_data),
        .o_last      (o_last),
        .o_port      (o_port),
        .i_bypass    (i_bypass),
        .o_init_done (o_init_done)
    );

    always #4 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
        end
    endtask

    // Advance to the falling edge and set output ready for the current mode
    task automatic tick();
        logic [31:0] r;
        @(negedge clk);
        r = rand32();
        case (ready_mode)
            0:       i_ready = 1'b1;
            1:       i_ready = r[0];
            default: i_ready = 1'b0;
        endcase
    endtask

    task automatic send_packet(input int len, input logic [PW-1:0] port);
        logic [DW-1:0] word;
        logic [31:0]   r;
        logic          accepted;
        for (int idx = 0; idx < len; idx++) begin
            word     = rand32();
            accepted = 1'b0;
            while (!accepted) begin
                tick();
                i_valid = 1'b1;
                i_data  = word;
                i_last  = (idx == len - 1);
                i_port  = port;
                #1;
                accepted = o_ready;
            end
            exp_q.push_back({port, i_last, word});
            // Occasional idle cycle between words under random back-pressure
            r = rand32();
            if (ready_mode == 1 && r[2:0] == 3'd0) begin
                tick();
                i_valid = 1'b0;
            end
        end
    endtask

    task automatic send_random_packet();
        logic [31:0] r;
        r = rand32();
        send_packet(int'(r[3:0]) + 1, r[8:7]);
    endtask

    task automatic drain();
        tick();
        i_valid = 1'b0;
        i_last  = 1'b0;
        while (exp_q.size() != 0) begin
            tick();
        end
        // Let the last buffer return to the pool
        repeat (4) tick();
    endtask

    // --------------------
    // Output monitor
    // --------------------
    always @(posedge clk) begin
        if (i_rst_n && !i_bypass) begin
            if (!o_init_done) begin
                check("valid before init", 64'(0), 64'(o_valid));
            end
            if (stall_q) begin
                check("held valid", 64'(1), 64'(o_valid));
                check("held data", 64'(held_data), 64'(o_data));
            end
            if (o_valid && i_ready) begin
                if (exp_q.size() == 0) begin
                    n_errors++;
                    $display("%s: output word seen while no input word was waiting",
                             test_name);
                end else begin
                    exp_word = exp_q.pop_front();
                    check("data", 64'(exp_word[DW-1:0]), 64'(o_data));
                    check("last", 64'(exp_word[DW]), 64'(o_last));
                    check("port", 64'(exp_word[PW+DW:DW+1]), 64'(o_port));
                end
            end
            stall_q   = o_valid && !i_ready;
            held_data = o_data;
        end else begin
            stall_q = 1'b0;
        end
    end

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles in %s",
                 TIMEOUT_CYC, test_name);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
        $display("tests failed");
        $finish;
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        int          cycles;
        logic [31:0] r;
        clk        = 1'b0;
        i_rst_n    = 1'b0;
        i_valid    = 1'b0;
        i_data     = '0;
        i_last     = 1'b0;
        i_port     = '0;
        i_ready    = 1'b0;
        i_bypass   = 1'b0;
        rng        = 32'd40088;
        ready_mode = 0;
        n_checks   = 0;
        n_errors   = 0;
        stall_q    = 1'b0;
        test_name  = "init";

        repeat (16) tick();
        i_rst_n = 1'b1;

        // Input offered during init must be held off
        i_valid = 1'b1;
        i_data  = rand32();
        cycles  = 0;
        while (!o_init_done) begin
            check("ready before init", 64'(0), 64'(o_ready));
            tick();
            cycles++;
        end
        i_valid = 1'b0;
        check("init cycles", 64'(egress_q_pkg::NUM_BUFFERS + 1), 64'(cycles));

        test_name  = "in_order";
        ready_mode = 0;
        repeat (NUM_PKTS) send_random_packet();
        drain();

        test_name  = "back_pressure";
        ready_mode = 1;
        repeat (NUM_PKTS) send_random_packet();
        drain();

        // Stalled output keeps every buffer busy
        test_name  = "exhaustion";
        ready_mode = 2;
        repeat (egress_q_pkg::NUM_BUFFERS) send_random_packet();
        tick();
        i_valid = 1'b0;
        repeat (50) begin
            #1;
            check("ready when full", 64'(0), 64'(o_ready));
            tick();
        end
        ready_mode = 0;
        send_random_packet();
        drain();

        test_name  = "bypass";
        ready_mode = 1;
        i_bypass   = 1'b1;
        repeat (BYP_WORDS) begin
            tick();
            r       = rand32();
            i_valid = r[0];
            i_last  = r[1];
            i_port  = r[3:2];
            i_data  = rand32();
            #1;
            check("valid", 64'(i_valid), 64'(o_valid));
            check("data", 64'(i_data), 64'(o_data));
            check("last", 64'(i_last), 64'(o_last));
            check("port", 64'(i_port), 64'(o_port));
            check("ready", 64'(i_ready), 64'(o_ready));
        end
        tick();
        i_bypass = 1'b0;
        i_valid  = 1'b0;
        repeat (4) tick();

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/egress_q_top.sv
`timescale 1ns/100ps
`default_nettype none

module egress_q_top (
    input  logic                              clk,
    input  logic                              i_rst_n,
    input  logic                              i_valid,
    output logic                              o_ready,
    input  logic [egress_q_pkg::DATA_WID-1:0] i_data,
    input  logic                              i_last,
    input  logic [egress_q_pkg::PORT_WID-1:0] i_port,
    output logic                              o_valid,
    input  logic                              i_ready,
    output logic [egress_q_pkg::DATA_WID-1:0] o_data,
    output logic                              o_last,
    output logic [egress_q_pkg::PORT_WID-1:0] o_port,
    input  logic                              i_bypass,
    output logic                              o_init_done
);
    pkt_intf    in_pkt ();
    pkt_intf    out_pkt ();
    desc_intf   wr_desc ();
    desc_intf   q_desc ();
    buf_wr_intf buf_wr ();
    buf_rd_intf buf_rd ();

    logic q_empty;
    logic q_pop;

    // --------------------
    // Bypass mux
    // --------------------
    // Queue sees no traffic while bypass is on
    assign in_pkt.valid  = i_valid && !i_bypass;
    assign in_pkt.data   = i_data;
    assign in_pkt.last   = i_last;
    assign in_pkt.port   = i_port;
    assign out_pkt.ready = i_ready && !i_bypass;

    assign o_ready = i_bypass ? i_ready : in_pkt.ready;
    assign o_valid = i_bypass ? i_valid : out_pkt.valid;
    assign o_data  = i_bypass ? i_data  : out_pkt.data;
    assign o_last  = i_bypass ? i_last  : out_pkt.last;
    assign o_port  = i_bypass ? i_port  : out_pkt.port;

    // --------------------
    // Queue stages
    // --------------------
    buffer_pool u_buffer_pool (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_wr        (buf_wr),
        .i_rd        (buf_rd),
        .o_init_done (o_init_done)
    );

    pkt_writer u_pkt_writer (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_pkt       (in_pkt),
        .o_buf       (buf_wr),
        .o_desc      (wr_desc),
        .i_init_done (o_init_done)
    );

    desc_delay_fifo u_desc_delay_fifo (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_desc  (wr_desc),
        .o_desc  (q_desc),
        .i_pop   (q_pop),
        .o_empty (q_empty)
    );

    pkt_reader u_pkt_reader (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_desc  (q_desc),
        .i_empty (q_empty),
        .o_pop   (q_pop),
        .o_buf   (buf_rd),
        .o_pkt   (out_pkt)
    );

endmodule

`default_nettype wire

// File: hw/pkt_reader.sv
`timescale 1ns/100ps
`default_nettype none

module pkt_reader (
    input  logic       clk,
    input  logic       i_rst_n,
    desc_intf.dst      i_desc,
    input  logic       i_empty,
    output logic       o_pop,
    buf_rd_intf.reader o_buf,
    pkt_intf.src       o_pkt
);
    egress_q_pkg::rd_state_e              state;
    logic [egress_q_pkg::BUF_PTR_WID-1:0] ptr_q;
    logic [egress_q_pkg::LEN_WID-1:0]     len_q;
    logic [egress_q_pkg::PORT_WID-1:0]    port_q;
    logic [egress_q_pkg::LEN_WID-1:0]     rd_cnt;
    logic [egress_q_pkg::LEN_WID-1:0]     out_cnt;
    logic                                 rd_pend;
    logic                                 out_fire;
    logic                                 room;
    logic [2:0]                           occ;

    // Skid buffer for read data already in flight
    logic [egress_q_pkg::DATA_WID-1:0] skid_data [2];
    logic                              skid_wr;
    logic                              skid_rd;
    logic [1:0]                        skid_cnt;

    assign o_pop    = (state == egress_q_pkg::RD_IDLE) && i_desc.valid && !i_empty;
    assign out_fire = o_pkt.valid && o_pkt.ready;

    // --------------------
    // Read issue
    // --------------------
    // A read issued now lands after the current output word may have left
    assign occ  = {1'b0, skid_cnt} + {2'b00, rd_pend};
    assign room = occ < (3'd2 + {2'b00, out_fire});

    assign o_buf.rd_en    = (state == egress_q_pkg::RD_READ) && (rd_cnt < len_q) && room;
    assign o_buf.rd_ptr   = ptr_q;
    assign o_buf.rd_idx   = rd_cnt[egress_q_pkg::WORD_IDX_WID-1:0];
    assign o_buf.free_en  = (state == egress_q_pkg::RD_FREE);
    assign o_buf.free_ptr = ptr_q;

    assign o_pkt.valid = (skid_cnt != 2'd0);
    assign o_pkt.data  = skid_data[skid_rd];
    assign o_pkt.last  = (out_cnt == len_q - 1'b1);
    assign o_pkt.port  = port_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= egress_q_pkg::RD_IDLE;
            rd_cnt   <= '0;
            out_cnt  <= '0;
            rd_pend  <= 1'b0;
            skid_wr  <= 1'b0;
            skid_rd  <= 1'b0;
            skid_cnt <= '0;
        end else begin
            rd_pend <= o_buf.rd_en;
            if (rd_pend) begin
                skid_wr <= ~skid_wr;
            end
            if (out_fire) begin
                skid_rd <= ~skid_rd;
            end
            case ({rd_pend, out_fire})
                2'b10:   skid_cnt <= skid_cnt + 1'b1;
                2'b01:   skid_cnt <= skid_cnt - 1'b1;
                default: skid_cnt <= skid_cnt;
            endcase

            case (state)
                egress_q_pkg::RD_IDLE: begin
                    if (o_pop) begin
                        state <= egress_q_pkg::RD_READ;
                    end
                end
                egress_q_pkg::RD_READ: begin
                    if (o_buf.rd_en) begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                    if (out_fire) begin
                        out_cnt <= out_cnt + 1'b1;
                    end
                    if (out_fire && o_pkt.last) begin
                        state <= egress_q_pkg::RD_FREE;
                    end
                end
                default: begin
                    // Buffer goes back to the pool in this cycle
                    rd_cnt  <= '0;
                    out_cnt <= '0;
                    state   <= egress_q_pkg::RD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            ptr_q  <= i_desc.buf_ptr;
            len_q  <= i_desc.len;
            port_q <= i_desc.port;
        end
        if (rd_pend) begin
            skid_data[skid_wr] <= o_buf.rd_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/desc_delay_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module desc_delay_fifo (
    input  logic  clk,
    input  logic  i_rst_n,
    desc_intf.dst i_desc,
    desc_intf.src o_desc,
    input  logic  i_pop,
    output logic  o_empty
);
    logic                                 dly_valid [egress_q_pkg::DESC_DELAY];
    logic [egress_q_pkg::BUF_PTR_WID-1:0] dly_ptr   [egress_q_pkg::DESC_DELAY];
    logic [egress_q_pkg::LEN_WID-1:0]     dly_len   [egress_q_pkg::DESC_DELAY];
    logic [egress_q_pkg::PORT_WID-1:0]    dly_port  [egress_q_pkg::DESC_DELAY];

    logic [egress_q_pkg::BUF_PTR_WID-1:0] fifo_ptr  [egress_q_pkg::DESC_DEPTH];
    logic [egress_q_pkg::LEN_WID-1:0]     fifo_len  [egress_q_pkg::DESC_DEPTH];
    logic [egress_q_pkg::PORT_WID-1:0]    fifo_port [egress_q_pkg::DESC_DEPTH];
    logic [egress_q_pkg::BUF_PTR_WID-1:0] wr_idx;
    logic [egress_q_pkg::BUF_PTR_WID-1:0] rd_idx;
    logic [egress_q_pkg::BUF_PTR_WID:0]   count;
    logic                                 push;

    // --------------------
    // Delay line
    // --------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < egress_q_pkg::DESC_DELAY; s++) begin
                dly_valid[s] <= 1'b0;
            end
        end else begin
            dly_valid[0] <= i_desc.valid;
            for (int s = 1; s < egress_q_pkg::DESC_DELAY; s++) begin
                dly_valid[s] <= dly_valid[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        dly_ptr[0]  <= i_desc.buf_ptr;
        dly_len[0]  <= i_desc.len;
        dly_port[0] <= i_desc.port;
        for (int s = 1; s < egress_q_pkg::DESC_DELAY; s++) begin
            dly_ptr[s]  <= dly_ptr[s-1];
            dly_len[s]  <= dly_len[s-1];
            dly_port[s] <= dly_port[s-1];
        end
    end

    // --------------------
    // Descriptor FIFO
    // --------------------
    assign push    = dly_valid[egress_q_pkg::DESC_DELAY-1];
    assign o_empty = (count == '0);

    // Head is shown as long as the FIFO holds an entry
    assign o_desc.valid   = !o_empty;
    assign o_desc.buf_ptr = fifo_ptr[rd_idx];
    assign o_desc.len     = fifo_len[rd_idx];
    assign o_desc.port    = fifo_port[rd_idx];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (i_pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
            case ({push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_ptr[wr_idx]  <= dly_ptr[egress_q_pkg::DESC_DELAY-1];
            fifo_len[wr_idx]  <= dly_len[egress_q_pkg::DESC_DELAY-1];
            fifo_port[wr_idx] <= dly_port[egress_q_pkg::DESC_DELAY-1];
        end
    end

endmodule

`default_nettype wire

// File: hw/pkt_writer.sv
`timescale 1ns/100ps
`default_nettype none

module pkt_writer (
    input  logic       clk,
    input  logic       i_rst_n,
    pkt_intf.dst       i_pkt,
    buf_wr_intf.writer o_buf,
    desc_intf.src      o_desc,
    input  logic       i_init_done
);
    egress_q_pkg::wr_state_e              state;
    logic                                 accept;
    logic                                 first;
    logic [egress_q_pkg::LEN_WID-1:0]     cnt_q;
    logic [egress_q_pkg::BUF_PTR_WID-1:0] ptr_q;
    logic [egress_q_pkg::PORT_WID-1:0]    port_q;

    // A new packet needs a free buffer while mid-packet words always have room
    assign i_pkt.ready = i_init_done &&
                         ((state == egress_q_pkg::WR_DATA) || o_buf.alloc_avail);
    assign accept      = i_pkt.valid && i_pkt.ready;
    assign first       = (state == egress_q_pkg::WR_IDLE);

    // --------------------
    // Buffer writes
    // --------------------
    // The popped pointer is used directly for the first word
    assign o_buf.alloc_req = accept && first;
    assign o_buf.wr_en     = accept;
    assign o_buf.wr_ptr    = first ? o_buf.alloc_ptr : ptr_q;
    assign o_buf.wr_idx    = cnt_q[egress_q_pkg::WORD_IDX_WID-1:0];
    assign o_buf.wr_data   = i_pkt.data;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= egress_q_pkg::WR_IDLE;
            cnt_q        <= '0;
            o_desc.valid <= 1'b0;
        end else begin
            // Descriptor strobe lands one cycle after the last word
            o_desc.valid <= accept && i_pkt.last;
            if (accept) begin
                if (i_pkt.last) begin
                    state <= egress_q_pkg::WR_IDLE;
                    cnt_q <= '0;
                end else begin
                    state <= egress_q_pkg::WR_DATA;
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    // --------------------
    // Descriptor build
    // --------------------
    always_ff @(posedge clk) begin
        if (o_buf.alloc_req) begin
            ptr_q  <= o_buf.alloc_ptr;
            port_q <= i_pkt.port;
        end
        if (accept && i_pkt.last) begin
            o_desc.buf_ptr <= o_buf.wr_ptr;
            o_desc.len     <= cnt_q + 1'b1;
            // Single-word packets take the port straight from the input
            o_desc.port    <= first ? i_pkt.port : port_q;
        end
    end

endmodule

`default_nettype wire

// File: hw/buffer_pool.sv
`timescale 1ns/100ps
`default_nettype none

module buffer_pool (
    input  logic     clk,
    input  logic     i_rst_n,
    buf_wr_intf.pool i_wr,
    buf_rd_intf.pool i_rd,
    output logic     o_init_done
);
    logic [egress_q_pkg::DATA_WID-1:0] mem [egress_q_pkg::NUM_BUFFERS*egress_q_pkg::BUFFER_WORDS];

    logic [egress_q_pkg::BUF_PTR_WID-1:0] free_list [egress_q_pkg::NUM_BUFFERS];
    logic [egress_q_pkg::BUF_PTR_WID-1:0] head;
    logic [egress_q_pkg::BUF_PTR_WID-1:0] tail;
    logic [egress_q_pkg::BUF_PTR_WID:0]   count;
    logic [egress_q_pkg::BUF_PTR_WID:0]   init_cnt;
    logic                                 filling;
    logic                                 push;
    logic                                 pop;
    logic [egress_q_pkg::BUF_PTR_WID-1:0] push_ptr;

    // --------------------
    // Free pointer list
    // --------------------
    // Initial fill pushes pointers 0 to NUM_BUFFERS-1, one per cycle
    assign filling  = !o_init_done &&
                      (init_cnt < (egress_q_pkg::BUF_PTR_WID+1)'(egress_q_pkg::NUM_BUFFERS));
    assign push     = filling || i_rd.free_en;
    assign push_ptr = filling ? init_cnt[egress_q_pkg::BUF_PTR_WID-1:0] : i_rd.free_ptr;
    assign pop      = i_wr.alloc_req;

    assign i_wr.alloc_avail = (count != '0);
    assign i_wr.alloc_ptr   = free_list[head];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            init_cnt    <= '0;
            o_init_done <= 1'b0;
        end else begin
            if (filling) begin
                init_cnt <= init_cnt + 1'b1;
            end
            if (init_cnt == (egress_q_pkg::BUF_PTR_WID+1)'(egress_q_pkg::NUM_BUFFERS)) begin
                o_init_done <= 1'b1;
            end
            // Pointers wrap naturally since the list depth is a power of two
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            free_list[tail] <= push_ptr;
        end
    end

    // --------------------
    // Packet RAM
    // --------------------
    always_ff @(posedge clk) begin
        if (i_wr.wr_en) begin
            mem[{i_wr.wr_ptr, i_wr.wr_idx}] <= i_wr.wr_data;
        end
        if (i_rd.rd_en) begin
            i_rd.rd_data <= mem[{i_rd.rd_ptr, i_rd.rd_idx}];
        end
    end

endmodule

`default_nettype wire

// File: hw/egress_q_intfs.sv
`timescale 1ns/100ps
`default_nettype none

// Packet word stream with valid/ready handshake
interface pkt_intf;
    logic                              valid;
    logic                              ready;
    logic [egress_q_pkg::DATA_WID-1:0] data;
    logic                              last;
    // Held constant for the whole packet
    logic [egress_q_pkg::PORT_WID-1:0] port;

    modport src (output valid, data, last, port, input ready);
    modport dst (input valid, data, last, port, output ready);
endinterface

// Packet descriptor with buffer pointer, length and port
interface desc_intf;
    logic                                 valid;
    logic [egress_q_pkg::BUF_PTR_WID-1:0] buf_ptr;
    logic [egress_q_pkg::LEN_WID-1:0]     len;
    logic [egress_q_pkg::PORT_WID-1:0]    port;

    modport src (output valid, buf_ptr, len, port);
    modport dst (input valid, buf_ptr, len, port);
endinterface

// Buffer allocation and word writes
interface buf_wr_intf;
    logic                                  alloc_req;
    logic [egress_q_pkg::BUF_PTR_WID-1:0]  alloc_ptr;
    logic                                  alloc_avail;
    logic                                  wr_en;
    logic [egress_q_pkg::BUF_PTR_WID-1:0]  wr_ptr;
    logic [egress_q_pkg::WORD_IDX_WID-1:0] wr_idx;
    logic [egress_q_pkg::DATA_WID-1:0]     wr_data;

    modport writer (
        output alloc_req, wr_en, wr_ptr, wr_idx, wr_data,
        input  alloc_ptr, alloc_avail
    );
    modport pool (
        input  alloc_req, wr_en, wr_ptr, wr_idx, wr_data,
        output alloc_ptr, alloc_avail
    );
endinterface

// Buffer word reads and buffer release
interface buf_rd_intf;
    logic                                  rd_en;
    logic [egress_q_pkg::BUF_PTR_WID-1:0]  rd_ptr;
    logic [egress_q_pkg::WORD_IDX_WID-1:0] rd_idx;
    // Valid one cycle after rd_en
    logic [egress_q_pkg::DATA_WID-1:0]     rd_data;
    logic                                  free_en;
    logic [egress_q_pkg::BUF_PTR_WID-1:0]  free_ptr;

    modport reader (output rd_en, rd_ptr, rd_idx, free_en, free_ptr, input rd_data);
    modport pool (input rd_en, rd_ptr, rd_idx, free_en, free_ptr, output rd_data);
endinterface

`default_nettype wire

// File: hw/egress_q_pkg.sv
`default_nettype none

package egress_q_pkg;

    // --------------------
    // Stream and buffer sizes
    // --------------------
    localparam int DATA_WID = 32;
    localparam int PORT_WID = 2;

    localparam int NUM_BUFFERS = 8;
    localparam int BUF_PTR_WID = 3;

    // One buffer holds a whole packet
    localparam int BUFFER_WORDS = 16;
    localparam int WORD_IDX_WID = 4;
    localparam int LEN_WID      = 5;

    // --------------------
    // Descriptor path
    // --------------------
    // Delay keeps the descriptor behind the last buffer write
    localparam int DESC_DELAY = 2;
    // Never overflows since there are no more packets than buffers
    localparam int DESC_DEPTH = NUM_BUFFERS;

    // --------------------
    // FSM states
    // --------------------
    typedef enum logic {
        WR_IDLE,
        WR_DATA
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_READ,
        RD_FREE
    } rd_state_e;

endpackage

`default_nettype wire
